// ==== logic/elev_consts.svh ====
`ifndef elev_consts_svh
`define elev_consts_svh

// Building size
`define elev_floors 4

// Cargo slots in the car, addressed with 3 bits
`define elev_slots 8

// Clock cycles to travel one floor
`define elev_floor_ticks 6

// Clock cycles the door stays open after arrival
`define elev_door_ticks 10

`endif

// ==== logic/elev_cargo_pkg.sv ====
package elev_cargo_pkg;

    // Kind of object riding in a slot
    // obj_none marks a free slot
    typedef enum logic [1:0] {
        obj_none   = 2'd0,
        obj_box    = 2'd1,
        obj_crate  = 2'd2,
        obj_pallet = 2'd3
    } obj_type_e;

    // One cargo item as handed over by the loader and held in a slot
    typedef struct packed {
        obj_type_e  kind;
        logic [1:0] dest;
    } cargo_item_t;

endpackage

// ==== logic/elev_motion_pkg.sv ====
package elev_motion_pkg;

    // Car FSM states
    typedef enum logic [1:0] {
        car_idle = 2'd0,
        car_up   = 2'd1,
        car_down = 2'd2,
        car_door = 2'd3
    } car_state_e;

    // Car status seen by the loader side and the outside world
    // load_open is high while the car accepts new cargo
    typedef struct packed {
        car_state_e state;
        logic [1:0] floor;
        logic       load_open;
    } car_status_t;

endpackage

// ==== logic/load_intake.sv ====
`timescale 1ns/1ps

module load_intake (
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        load_req,
    input  elev_cargo_pkg::cargo_item_t load_item,
    input  logic                        has_room,
    input  elev_motion_pkg::car_status_t status,
    output logic                        load_ack,
    output logic                        store_wr,
    output elev_cargo_pkg::cargo_item_t store_item
);

    typedef enum logic {
        wait_req  = 1'b0,
        wait_drop = 1'b1
    } intake_state_e;

    intake_state_e state;

    // Write once per handshake, only with room in the store and the car open
    // A full store or a moving car simply leaves the request pending
    assign store_wr = (state == wait_req) && load_req && !load_ack &&
                      status.load_open && has_room;

    // Loader holds the item stable until ack, so it goes straight to the store
    assign store_item = load_item;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state    <= wait_req;
            load_ack <= 1'b0;
        end else begin
            case (state)
                wait_req: begin
                    if (store_wr) begin
                        state <= wait_drop;
                    end
                end
                wait_drop: begin
                    // Ack rises the cycle after the write has landed
                    if (!load_ack) begin
                        load_ack <= 1'b1;
                    end else if (!load_req) begin
                        load_ack <= 1'b0;
                        state    <= wait_req;
                    end
                end
                default: begin
                    state    <= wait_req;
                    load_ack <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== logic/cargo_store.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module cargo_store (
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        store_wr,
    input  elev_cargo_pkg::cargo_item_t store_item,
    input  logic                        unload,
    input  logic [1:0]                  floor,
    input  logic [2:0]                  read_addr,
    output elev_cargo_pkg::cargo_item_t read_item,
    output logic                        has_room,
    output logic                        head_valid,
    output logic [1:0]                  head_dest,
    output logic [`elev_floors-1:0]     pending_mask
);

    import elev_cargo_pkg::*;

    cargo_item_t slots [`elev_slots];
    logic [2:0]  free_idx;
    logic [2:0]  addr_q;

    // Lowest empty slot, scanned from the top so the lowest index wins
    always_comb begin
        has_room = 1'b0;
        free_idx = 3'd0;
        for (int i = `elev_slots - 1; i >= 0; i--) begin
            if (slots[i].kind == obj_none) begin
                has_room = 1'b1;
                free_idx = 3'(i);
            end
        end
    end

    // Summaries for the motion stage
    always_comb begin
        head_valid   = 1'b0;
        head_dest    = 2'd0;
        pending_mask = '0;
        for (int i = `elev_slots - 1; i >= 0; i--) begin
            if (slots[i].kind != obj_none) begin
                head_valid                  = 1'b1;
                head_dest                   = slots[i].dest;
                pending_mask[slots[i].dest] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            for (int i = 0; i < `elev_slots; i++) begin
                slots[i] <= '{kind: obj_none, dest: 2'd0};
            end
        end else begin
            // Unload drops everything bound for the current floor
            if (unload) begin
                for (int i = 0; i < `elev_slots; i++) begin
                    if (slots[i].kind != obj_none && slots[i].dest == floor) begin
                        slots[i] <= '{kind: obj_none, dest: 2'd0};
                    end
                end
            end
            // Write goes to the slot that was free before this edge's unload
            if (store_wr && has_room) begin
                slots[free_idx] <= store_item;
            end
        end
    end

    // Registered read address, data follows one cycle later
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            addr_q <= 3'd0;
        end else begin
            addr_q <= read_addr;
        end
    end

    assign read_item = slots[addr_q];

endmodule

// ==== logic/car_motion.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module car_motion (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         head_valid,
    input  logic [1:0]                   head_dest,
    input  logic [`elev_floors-1:0]      pending_mask,
    output logic                         unload,
    output elev_motion_pkg::car_status_t status
);

    import elev_motion_pkg::*;

    localparam int travel_w = $clog2(`elev_floor_ticks);
    localparam int door_w   = $clog2(`elev_door_ticks);

    car_state_e          state;
    logic [1:0]          floor;
    logic [travel_w-1:0] travel_cnt;
    logic [door_w-1:0]   door_cnt;
    logic [1:0]          next_floor;

    // Floor reached at the end of the current travel leg
    assign next_floor = (state == car_up) ? floor + 2'd1 : floor - 2'd1;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state      <= car_idle;
            floor      <= 2'd0;
            travel_cnt <= '0;
            door_cnt   <= '0;
            unload     <= 1'b0;
        end else begin
            unload <= 1'b0;
            case (state)
                car_idle: begin
                    travel_cnt <= '0;
                    door_cnt   <= '0;
                    // Cargo for this floor opens the door right away
                    if (pending_mask[floor]) begin
                        state  <= car_door;
                        unload <= 1'b1;
                    end else if (head_valid) begin
                        if (head_dest > floor) begin
                            state <= car_up;
                        end else begin
                            state <= car_down;
                        end
                    end
                end
                car_up, car_down: begin
                    if (travel_cnt == travel_w'(`elev_floor_ticks - 1)) begin
                        travel_cnt <= '0;
                        floor      <= next_floor;
                        // Stop at head_dest or at any floor with riders for it
                        if (pending_mask[next_floor]) begin
                            state    <= car_door;
                            door_cnt <= '0;
                            unload   <= 1'b1;
                        end else if (!head_valid) begin
                            state <= car_idle;
                        end
                    end else begin
                        travel_cnt <= travel_cnt + travel_w'(1);
                    end
                end
                car_door: begin
                    if (door_cnt == door_w'(`elev_door_ticks - 1)) begin
                        door_cnt <= '0;
                        state    <= car_idle;
                    end else begin
                        door_cnt <= door_cnt + door_w'(1);
                    end
                end
                default: begin
                    state <= car_idle;
                end
            endcase
        end
    end

    // Loading is allowed only with the car at rest
    assign status = '{
        state:     state,
        floor:     floor,
        load_open: (state == car_idle) || (state == car_door)
    };

endmodule

// ==== logic/elevator_top.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module elevator_top (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         load_req,
    input  elev_cargo_pkg::cargo_item_t  load_item,
    input  logic [2:0]                   read_addr,
    output logic                         load_ack,
    output elev_cargo_pkg::cargo_item_t  read_item,
    output logic                         has_room,
    output elev_motion_pkg::car_status_t status,
    output logic                         unload
);

    import elev_cargo_pkg::*;

    logic                    store_wr;
    cargo_item_t             store_item;
    logic                    head_valid;
    logic [1:0]              head_dest;
    logic [`elev_floors-1:0] pending_mask;

    // Loader handshake into single-cycle store writes
    load_intake load_intake_i (
        .clk        (clk),
        .clear      (clear),
        .load_req   (load_req),
        .load_item  (load_item),
        .has_room   (has_room),
        .status     (status),
        .load_ack   (load_ack),
        .store_wr   (store_wr),
        .store_item (store_item)
    );

    cargo_store cargo_store_i (
        .clk          (clk),
        .clear        (clear),
        .store_wr     (store_wr),
        .store_item   (store_item),
        .unload       (unload),
        .floor        (status.floor),
        .read_addr    (read_addr),
        .read_item    (read_item),
        .has_room     (has_room),
        .head_valid   (head_valid),
        .head_dest    (head_dest),
        .pending_mask (pending_mask)
    );

    // Motion sees only the store summaries, never the slots
    car_motion car_motion_i (
        .clk          (clk),
        .clear        (clear),
        .head_valid   (head_valid),
        .head_dest    (head_dest),
        .pending_mask (pending_mask),
        .unload       (unload),
        .status       (status)
    );

endmodule

// ==== verif/elevator_chk.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module elevator_chk (
    input logic                         clk,
    input logic                         clear,
    input logic                         load_req,
    input logic                         load_ack,
    input logic                         unload,
    input elev_motion_pkg::car_status_t status
);

    import elev_motion_pkg::*;

    logic [1:0] floor_q;
    logic [3:0] gap;

    // Cycles since the last floor change, saturating
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            floor_q <= 2'd0;
            gap     <= 4'hf;
        end else begin
            floor_q <= status.floor;
            if (status.floor != floor_q) begin
                gap <= 4'd0;
            end else if (gap != 4'hf) begin
                gap <= gap + 4'd1;
            end
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (clear)
        $rose(load_ack) |-> $past(load_req))
        else $error("load_ack rose while load_req was low");

    unload_in_door: assert property (@(posedge clk) disable iff (clear)
        unload |-> (status.state == car_door))
        else $error("unload pulse outside the door state");

    floor_step: assert property (@(posedge clk) disable iff (clear)
        (status.floor != floor_q) |-> (gap >= 4'(`elev_floor_ticks - 1)) &&
        ((status.floor - floor_q == 2'd1) || (floor_q - status.floor == 2'd1)))
        else $error("floor moved too far or too fast");

    door_holds_floor: assert property (@(posedge clk) disable iff (clear)
        (status.state == car_door) |=> (status.floor == floor_q))
        else $error("floor changed with the door open");

endmodule

bind elevator_top elevator_chk elevator_chk_i (
    .clk      (clk),
    .clear    (clear),
    .load_req (load_req),
    .load_ack (load_ack),
    .unload   (unload),
    .status   (status)
);

// ==== verif/elevator_mon.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module elevator_mon (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         load_req,
    input  elev_cargo_pkg::cargo_item_t  load_item,
    input  logic                         load_ack,
    input  logic [2:0]                   read_addr,
    input  elev_cargo_pkg::cargo_item_t  read_item,
    input  logic                         has_room,
    input  elev_motion_pkg::car_status_t status,
    input  logic                         unload,
    output int                           error_count,
    output int                           held
);

    import elev_cargo_pkg::*;
    import elev_motion_pkg::*;

    cargo_item_t model [`elev_slots];
    logic [2:0]  addr_prev;
    logic        wrote;
    logic        m_ack;
    car_state_e  m_state;
    logic [1:0]  m_floor;
    logic        m_unload;
    int          tcnt;
    int          dcnt;

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk or posedge clear) begin : step
        logic [`elev_floors-1:0] pend;
        logic                    any;
        logic                    room;
        logic [1:0]              head;
        logic [2:0]              free_idx;
        logic [1:0]              old_floor;
        logic [1:0]              nf;
        logic                    old_unload;
        logic                    open;
        logic                    wr;
        if (clear) begin
            for (int i = 0; i < `elev_slots; i++) begin
                model[i] = '0;
            end
            addr_prev = 3'd0;
            wrote     = 1'b0;
            m_ack     = 1'b0;
            m_state   = car_idle;
            m_floor   = 2'd0;
            m_unload  = 1'b0;
            tcnt      = 0;
            dcnt      = 0;
            held      = 0;
            error_count = 0;
        end else begin
            pend     = '0;
            any      = 1'b0;
            room     = 1'b0;
            head     = 2'd0;
            free_idx = 3'd0;
            // Descending scan so the lowest slot wins
            for (int i = `elev_slots - 1; i >= 0; i--) begin
                if (model[i].kind == obj_none) begin
                    room     = 1'b1;
                    free_idx = 3'(i);
                end else begin
                    any                = 1'b1;
                    head               = model[i].dest;
                    pend[model[i].dest] = 1'b1;
                end
            end
            open = (m_state == car_idle) || (m_state == car_door);

            compare_value("read_item", 8'(read_item), 8'(model[addr_prev]));
            compare_value("has_room", 8'(has_room), 8'(room));
            compare_value("load_ack", 8'(load_ack), 8'(m_ack));
            compare_value("status.state", 8'(status.state), 8'(m_state));
            compare_value("status.floor", 8'(status.floor), 8'(m_floor));
            compare_value("status.load_open", 8'(status.load_open), 8'(open));
            compare_value("unload", 8'(unload), 8'(m_unload));

            // Loader handshake, one store write per request, ack the cycle after it
            wr = load_req && !m_ack && !wrote && open && room;
            if (m_ack && !load_req) begin
                m_ack = 1'b0;
                wrote = 1'b0;
            end else if (wrote && !m_ack) begin
                m_ack = 1'b1;
            end
            if (wr) begin
                wrote = 1'b1;
            end

            // Car motion
            old_floor  = m_floor;
            old_unload = m_unload;
            m_unload   = 1'b0;
            case (m_state)
                car_idle: begin
                    if (pend[m_floor]) begin
                        m_state  = car_door;
                        m_unload = 1'b1;
                        dcnt     = 0;
                    end else if (any) begin
                        m_state = (head > m_floor) ? car_up : car_down;
                        tcnt    = 0;
                    end
                end
                car_up, car_down: begin
                    nf = (m_state == car_up) ? m_floor + 2'd1 : m_floor - 2'd1;
                    if (tcnt == `elev_floor_ticks - 1) begin
                        tcnt    = 0;
                        m_floor = nf;
                        if (pend[nf]) begin
                            m_state  = car_door;
                            m_unload = 1'b1;
                            dcnt     = 0;
                        end else if (!any) begin
                            m_state = car_idle;
                        end
                    end else begin
                        tcnt++;
                    end
                end
                default: begin
                    if (dcnt == `elev_door_ticks - 1) begin
                        m_state = car_idle;
                    end else begin
                        dcnt++;
                    end
                end
            endcase

            // Slots: unload by floor, then write into the slot free before it
            if (old_unload) begin
                for (int i = 0; i < `elev_slots; i++) begin
                    if (model[i].kind != obj_none && model[i].dest == old_floor) begin
                        model[i] = '0;
                    end
                end
            end
            if (wr) begin
                model[free_idx] = load_item;
            end

            held = 0;
            for (int i = 0; i < `elev_slots; i++) begin
                if (model[i].kind != obj_none) begin
                    held++;
                end
            end
            addr_prev = read_addr;
        end
    end

endmodule

// ==== verif/elevator_tb.sv ====
`timescale 1ns/1ps

`include "elev_consts.svh"

module elevator_tb;

    import elev_cargo_pkg::*;
    import elev_motion_pkg::*;

    localparam int n_items = 60;
    localparam int n_fill = 24;
    localparam int item_bound = `elev_floors * `elev_floor_ticks + `elev_door_ticks + 20;
    // Extra room for reset, the first sweep and the final drain
    localparam int timeout_cycles = (n_items + n_fill) * item_bound + 100;

    logic        clk;
    logic        clear;
    logic        load_req;
    cargo_item_t load_item;
    logic [2:0]  read_addr;
    logic        load_ack;
    cargo_item_t read_item;
    logic        has_room;
    car_status_t status;
    logic        unload;
    int          mon_errors;
    int          held;
    int          tb_errors;
    int          full_waits;

    elevator_top elevator_top_i (
        .clk       (clk),
        .clear     (clear),
        .load_req  (load_req),
        .load_item (load_item),
        .read_addr (read_addr),
        .load_ack  (load_ack),
        .read_item (read_item),
        .has_room  (has_room),
        .status    (status),
        .unload    (unload)
    );

    elevator_mon mon_i (
        .clk         (clk),
        .clear       (clear),
        .load_req    (load_req),
        .load_item   (load_item),
        .load_ack    (load_ack),
        .read_addr   (read_addr),
        .read_item   (read_item),
        .has_room    (has_room),
        .status      (status),
        .unload      (unload),
        .error_count (mon_errors),
        .held        (held)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Requests held back by a full store
    always @(negedge clk) begin
        if (load_req && !has_room) begin
            full_waits++;
        end
    end

    task automatic expect_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic check_reset_state();
        expect_value("load_ack", 8'(load_ack), 8'h00);
        expect_value("status.state", 8'(status.state), 8'(car_idle));
        expect_value("status.floor", 8'(status.floor), 8'h00);
        expect_value("has_room", 8'(has_room), 8'h01);
    endtask

    // Monitor compares each slot as the registered address comes through
    task automatic sweep_read_port();
        for (int a = 0; a < `elev_slots; a++) begin
            read_addr = 3'(a);
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic hand_over(input cargo_item_t item);
        load_item = item;
        load_req  = 1'b1;
        do @(negedge clk); while (!load_ack);
        load_req = 1'b0;
        do @(negedge clk); while (load_ack);
    endtask

    task automatic wait_until_empty();
        while (!(status.state == car_idle && held == 0)) begin
            @(negedge clk);
        end
    endtask

    // Back-to-back loads alternating between this floor and another one
    // Cargo for this floor keeps the door reopening while the rest piles up
    task automatic fill_store(input int count);
        cargo_item_t item;
        logic [1:0]  here;
        logic [1:0]  other;
        here  = status.floor;
        other = here ^ 2'd2;
        for (int n = 0; n < count; n++) begin
            item.kind = obj_type_e'(2'($urandom_range(3, 1)));
            item.dest = (n % 2 == 0) ? here : other;
            hand_over(item);
        end
    endtask

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the loader or the car got stuck", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        cargo_item_t item;
        logic [1:0]  kind_bits;
        int          gap;
        void'($urandom(32'h765879c6));
        tb_errors  = 0;
        full_waits = 0;
        clear      = 1'b1;
        load_req   = 1'b0;
        load_item  = '0;
        read_addr  = 3'd0;
        repeat (2) @(negedge clk);
        clear = 1'b0;

        check_reset_state();
        sweep_read_port();

        for (int n = 0; n < n_items; n++) begin
            kind_bits = 2'($urandom_range(3, 1));
            item.kind = obj_type_e'(kind_bits);
            item.dest = 2'($urandom_range(3, 0));
            hand_over(item);
            sweep_read_port();
            gap = $urandom_range(3, 0);
            repeat (gap) @(negedge clk);
        end

        // Fill the store from a resting car until the loader is held back
        wait_until_empty();
        fill_store(n_fill);
        if (full_waits == 0) begin
            $display("Store never filled, no request was held back by a full store");
            tb_errors++;
        end

        // Let the car deliver what is left
        wait_until_empty();
        sweep_read_port();

        $display("Run finished: testbench errors %0d, monitor errors %0d", tb_errors, mon_errors);
        if (tb_errors + mon_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/elev_cargo_pkg.sv
logic/elev_motion_pkg.sv
logic/load_intake.sv
logic/cargo_store.sv
logic/car_motion.sv
logic/elevator_top.sv
verif/elevator_chk.sv
verif/elevator_mon.sv
verif/elevator_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the elevator testbench with Verilator
rm -rf obj_dir
verilator --binary --timing --assert --top-module elevator_tb -f vlog.f \
    -o elevator_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/elevator_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
exit 0
